// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic jtag_clk,
    output logic sys_rst_n
);

    initial
    begin
        jtag_clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD) jtag_clk = ~jtag_clk;
        end
    end

    // reset released on a rising edge, like any other input
    initial
    begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge jtag_clk);
        sys_rst_n <= 1'b1;
    end

endmodule

// File: dv/tb_jtag_tap.sv
`timescale 1ns/10ps

module tb_jtag_tap
    import tap_state_pkg::*;
    import tap_instr_pkg::*;
;

    localparam logic [31:0] EXP_JTAG_ID     = 32'h12345678;
    localparam logic [31:0] EXP_CUSTOM_INIT = 32'h0A0B0C0D;
    localparam logic [31:0] UNKNOWN_INSTR   = 32'h00000123;

    logic       jtag_clk;
    logic       sys_rst_n;
    logic       jtag_tms;
    logic       jtag_tdi;
    logic       jtag_tdo;
    led_t       led;

    int          errors;
    int          checks;
    string       cur_test;
    tap_state_t  model;
    logic [15:0] visited;
    logic [31:0] lcg_seed;

    tb_clock_gen u_clock_gen (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n)
    );

    jtag_tap_top DUT (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .jtag_tdi  (jtag_tdi),
        .jtag_tdo  (jtag_tdo),
        .led       (led)
    );

    // standard 1149.1 transition table
    function automatic tap_state_t next_state(input tap_state_t s, input logic tms);
        case (s)
            TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       return tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       return tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
            default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        endcase
    endfunction

    // LEDs are active low
    function automatic led_t expected_led(input tap_state_t s);
        return ~{2'b00, 4'(s)};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_seed = lcg_seed * 32'd1103515245 + 32'd12345;
        return lcg_seed;
    endfunction

    // one clock: sample outputs, advance the model, drive the next inputs
    task automatic step(input logic tms_val, input logic tdi_val, output logic tdo_seen);
        @(posedge jtag_clk);
        tdo_seen = jtag_tdo;
        checks++;
        if (led !== expected_led(model))
        begin
            $display("** Error %s: led expected %h actual %h", cur_test,
                     expected_led(model), led);
            errors++;
        end
        // state number as shown by the DUT
        visited[~led[3:0]] = 1'b1;
        model = next_state(model, jtag_tms);
        jtag_tms <= tms_val;
        jtag_tdi <= tdi_val;
    endtask

    // five ones reach TEST_LOGIC_RESET, then settle in RUN_TEST_IDLE
    task automatic go_idle();
        logic seen;
        repeat (5) step(1'b1, 1'b0, seen);
        step(1'b0, 1'b0, seen);
        step(1'b0, 1'b0, seen);
    endtask

    // 33 shifts, a leading dummy bit so the chain ends up holding data_in
    task automatic scan(input logic is_ir, input logic [31:0] data_in,
                        output logic [31:0] data_out);
        logic seen;
        logic bit_in;
        step(1'b1, 1'b0, seen);
        if (is_ir)
        begin
            step(1'b1, 1'b0, seen);
        end
        step(1'b0, 1'b0, seen);
        step(1'b0, 1'b0, seen);
        for (int j = 0; j <= 32; j++)
        begin
            bit_in = 1'b0;
            if (j > 0)
            begin
                bit_in = data_in[j-1];
            end
            step(j == 32, bit_in, seen);
            if (j >= 2)
            begin
                data_out[j-2] = seen;
            end
        end
        step(1'b1, 1'b0, seen);
        data_out[31] = seen;
        // through UPDATE back to idle, one more edge for the write-back
        step(1'b0, 1'b0, seen);
        step(1'b0, 1'b0, seen);
    endtask

    task automatic test_reset();
        logic seen;
        cur_test = "reset";
        repeat (3) step(1'b1, 1'b0, seen);
        checks++;
        if (led !== 6'h3F)
        begin
            $display("** Error %s: led expected %h actual %h", cur_test, 6'h3F, led);
            errors++;
        end
        // walk into SHIFT_IR, then five ones
        step(1'b0, 1'b0, seen);
        step(1'b1, 1'b0, seen);
        step(1'b1, 1'b0, seen);
        step(1'b0, 1'b0, seen);
        step(1'b0, 1'b0, seen);
        repeat (5) step(1'b1, 1'b0, seen);
        // led shows the reached state one edge later
        repeat (2) step(1'b1, 1'b0, seen);
        checks++;
        if (led !== 6'h3F)
        begin
            $display("** Error %s: led expected %h actual %h", cur_test, 6'h3F, led);
            errors++;
        end
    endtask

    task automatic test_state_walk();
        logic        seen;
        logic [24:0] walk;
        cur_test = "state_walk";
        visited = '0;
        // applied from bit 0 upward
        // IR branch first, so the DR pass updates bypass and not IDCODE
        walk = 25'b1_1111_1111_1101_0011_1010_0110;
        for (int i = 0; i < 25; i++)
        begin
            step(walk[i], 1'b0, seen);
        end
        step(1'b1, 1'b0, seen);
        checks++;
        if (visited !== 16'hFFFF)
        begin
            $display("** Error %s: visited expected %h actual %h", cur_test,
                     16'hFFFF, visited);
            errors++;
        end
    endtask

    task automatic test_idcode_read();
        logic [31:0] got;
        cur_test = "idcode_read";
        go_idle();
        // shift the ID back in so the writable IDCODE keeps its value
        scan(1'b0, EXP_JTAG_ID, got);
        checks++;
        if (got !== EXP_JTAG_ID)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, EXP_JTAG_ID, got);
            errors++;
        end
    endtask

    task automatic check_bypass(input string name);
        logic [31:0] data;
        logic [31:0] got;
        data = lcg_next();
        scan(1'b0, data, got);
        checks++;
        if (got[31:2] !== data[29:0])
        begin
            $display("** Error %s: expected %h actual %h", name, data[29:0], got[31:2]);
            errors++;
        end
    endtask

    task automatic test_ir_bypass();
        logic [31:0] got;
        cur_test = "ir_bypass";
        scan(1'b1, BYPASS_INSTR, got);
        checks++;
        if (got !== IDCODE_INSTR)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, IDCODE_INSTR, got);
            errors++;
        end
        check_bypass(cur_test);
        // unknown code behaves as bypass too
        scan(1'b1, UNKNOWN_INSTR, got);
        checks++;
        if (got !== BYPASS_INSTR)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, BYPASS_INSTR, got);
            errors++;
        end
        check_bypass("ir_unknown");
    endtask

    task automatic test_custom();
        logic [31:0] got;
        logic [31:0] value;
        cur_test = "custom";
        scan(1'b1, CUSTOM_INSTR, got);
        value = lcg_next();
        scan(1'b0, value, got);
        checks++;
        if (got !== EXP_CUSTOM_INIT)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, EXP_CUSTOM_INIT, got);
            errors++;
        end
        scan(1'b0, value, got);
        checks++;
        if (got !== value)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, value, got);
            errors++;
        end
    endtask

    task automatic test_reset_idcode();
        logic [31:0] got;
        cur_test = "reset_idcode";
        go_idle();
        scan(1'b0, EXP_JTAG_ID, got);
        checks++;
        if (got !== EXP_JTAG_ID)
        begin
            $display("** Error %s: expected %h actual %h", cur_test, EXP_JTAG_ID, got);
            errors++;
        end
    endtask

    // overall limit in case a scan never returns
    initial
    begin
        repeat (20000) @(posedge jtag_clk);
        $display("timeout: the test sequence did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        int wait_cycles;
        jtag_tms  = 1'b1;
        jtag_tdi  = 1'b0;
        errors    = 0;
        checks    = 0;
        lcg_seed  = 32'ha599;
        model     = TEST_LOGIC_RESET;
        visited   = '0;
        cur_test  = "init";
        wait_cycles = 0;
        while (sys_rst_n !== 1'b1 && wait_cycles < 100)
        begin
            @(posedge jtag_clk);
            wait_cycles++;
        end
        if (sys_rst_n !== 1'b1)
        begin
            $display("reset was never released");
            errors++;
        end
        else
        begin
            test_reset();
            test_state_walk();
            test_idcode_read();
            test_ir_bypass();
            test_custom();
            test_reset_idcode();
        end
        $display("summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/data_register_bank.sv
`timescale 1ns/10ps

module data_register_bank
    import tap_state_pkg::*;
    import tap_instr_pkg::*;
#(
    parameter data_word_t JTAG_ID     = 32'h12345678,
    parameter data_word_t CUSTOM_INIT = 32'h0A0B0C0D
) (
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  tap_ctrl_t  ctrl,
    input  dr_select_t dr_select,
    input  logic       jtag_tdi,
    output logic       dr_serial
);

    data_word_t idcode_q;
    data_word_t custom_q;
    data_word_t capture_word;
    data_word_t chain_word;
    logic       word_sel;
    logic       word_serial;
    logic       write_back_q;
    logic       bypass_word;
    logic       bypass_serial;

    // IDCODE and custom share one 32-bit chain
    assign word_sel     = dr_select.sel_idcode || dr_select.sel_custom;
    assign capture_word = dr_select.sel_custom ? custom_q : idcode_q;

    scan_register #(
        .payload_t (data_word_t)
    ) u_dr_chain (
        .jtag_clk      (jtag_clk),
        .sys_rst_n     (sys_rst_n),
        .reset_value   (JTAG_ID),
        .capture       (ctrl.capture_dr && word_sel),
        .capture_value (capture_word),
        .shift         (ctrl.shift_dr && word_sel),
        .tdi           (jtag_tdi),
        .update        (ctrl.update_dr && word_sel),
        .parallel_out  (chain_word),
        .serial_out    (word_serial)
    );

    // one-bit bypass, captures its own last update
    scan_register #(
        .payload_t (logic)
    ) u_bypass_chain (
        .jtag_clk      (jtag_clk),
        .sys_rst_n     (sys_rst_n),
        .reset_value   (1'b0),
        .capture       (ctrl.capture_dr && dr_select.sel_bypass),
        .capture_value (bypass_word),
        .shift         (ctrl.shift_dr && dr_select.sel_bypass),
        .tdi           (jtag_tdi),
        .update        (ctrl.update_dr && dr_select.sel_bypass),
        .parallel_out  (bypass_word),
        .serial_out    (bypass_serial)
    );

    // chain update stage lands in the selected register on the next edge,
    // state is still UPDATE_DR there so no capture can see the gap
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            write_back_q <= 1'b0;
            idcode_q     <= JTAG_ID;
            custom_q     <= CUSTOM_INIT;
        end
        else
        begin
            write_back_q <= ctrl.update_dr && word_sel;
            if (write_back_q && dr_select.sel_idcode)
            begin
                idcode_q <= chain_word;
            end
            if (write_back_q && dr_select.sel_custom)
            begin
                custom_q <= chain_word;
            end
        end
    end

    assign dr_serial = dr_select.sel_bypass ? bypass_serial : word_serial;

    a_select_onehot: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        $onehot({dr_select.sel_idcode, dr_select.sel_custom, dr_select.sel_bypass})
    );

endmodule

// File: logic/instruction_register.sv
`timescale 1ns/10ps

module instruction_register
    import tap_state_pkg::*;
    import tap_instr_pkg::*;
(
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  tap_ctrl_t  ctrl,
    input  logic       jtag_tdi,
    output dr_select_t dr_select,
    output logic       ir_serial
);

    instr_t instr;
    logic   ir_rst_n;

    // TEST_LOGIC_RESET reloads IDCODE through the chain's own reset
    assign ir_rst_n = sys_rst_n && !ctrl.logic_reset;

    // capture loads the current instruction for read-back
    scan_register #(
        .payload_t (instr_t)
    ) u_ir_chain (
        .jtag_clk      (jtag_clk),
        .sys_rst_n     (ir_rst_n),
        .reset_value   (IDCODE_INSTR),
        .capture       (ctrl.capture_ir),
        .capture_value (instr),
        .shift         (ctrl.shift_ir),
        .tdi           (jtag_tdi),
        .update        (ctrl.update_ir),
        .parallel_out  (instr),
        .serial_out    (ir_serial)
    );

    // anything not recognised falls back to bypass
    always_comb
    begin
        dr_select = '0;
        case (instr)
            IDCODE_INSTR: dr_select.sel_idcode = 1'b1;
            CUSTOM_INSTR: dr_select.sel_custom = 1'b1;
            BYPASS_INSTR: dr_select.sel_bypass = 1'b1;
            default:      dr_select.sel_bypass = 1'b1;
        endcase
    end

endmodule

// File: logic/jtag_tap_top.sv
`timescale 1ns/10ps

module jtag_tap_top
    import tap_state_pkg::*;
    import tap_instr_pkg::*;
#(
    parameter data_word_t JTAG_ID     = 32'h12345678,
    parameter data_word_t CUSTOM_INIT = 32'h0A0B0C0D
) (
    input  logic jtag_clk,
    input  logic sys_rst_n,
    input  logic jtag_tms,
    input  logic jtag_tdi,
    output logic jtag_tdo,
    output led_t led
);

    tap_ctrl_t  ctrl;
    dr_select_t dr_select;
    logic       ir_serial;
    logic       dr_serial;

    tap_controller u_tap_controller (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .ir_serial (ir_serial),
        .dr_serial (dr_serial),
        .ctrl      (ctrl),
        .led       (led),
        .jtag_tdo  (jtag_tdo)
    );

    instruction_register u_instruction_register (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .ctrl      (ctrl),
        .jtag_tdi  (jtag_tdi),
        .dr_select (dr_select),
        .ir_serial (ir_serial)
    );

    data_register_bank #(
        .JTAG_ID     (JTAG_ID),
        .CUSTOM_INIT (CUSTOM_INIT)
    ) u_data_register_bank (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .ctrl      (ctrl),
        .dr_select (dr_select),
        .jtag_tdi  (jtag_tdi),
        .dr_serial (dr_serial)
    );

endmodule

// File: logic/scan_register.sv
`timescale 1ns/10ps

module scan_register #(
    parameter type payload_t = logic
) (
    input  logic     jtag_clk,
    input  logic     sys_rst_n,
    input  payload_t reset_value,
    input  logic     capture,
    input  payload_t capture_value,
    input  logic     shift,
    input  logic     tdi,
    input  logic     update,
    output payload_t parallel_out,
    output logic     serial_out
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] chain_q;
    logic [W-1:0] chain_shifted;
    logic         save_q;
    payload_t     update_q;

    // shift right, new bit enters at the top
    always_comb
    begin
        chain_shifted = chain_q >> 1;
        chain_shifted[W-1] = tdi;
    end

    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            chain_q  <= '0;
            save_q   <= 1'b0;
            update_q <= reset_value;
        end
        else
        begin
            if (capture)
            begin
                chain_q <= capture_value;
            end
            else if (shift)
            begin
                // keep bit 0 for the falling-edge TDO register
                save_q  <= chain_q[0];
                chain_q <= chain_shifted;
            end
            if (update)
            begin
                update_q <= chain_q;
            end
        end
    end

    assign parallel_out = update_q;
    assign serial_out   = save_q;

    a_capture_shift: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        !(capture && shift)
    );

endmodule

// File: logic/tap_controller.sv
`timescale 1ns/10ps

module tap_controller
    import tap_state_pkg::*;
(
    input  logic      jtag_clk,
    input  logic      sys_rst_n,
    input  logic      jtag_tms,
    input  logic      ir_serial,
    input  logic      dr_serial,
    output tap_ctrl_t ctrl,
    output led_t      led,
    output logic      jtag_tdo
);

    tap_state_t state_q;
    tap_state_t state_d;
    logic       tdo_q;

    // next state table, one step per rising edge
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            TEST_LOGIC_RESET: state_d = jtag_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = jtag_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_d = jtag_tms ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_d = jtag_tms ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = jtag_tms ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = jtag_tms ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = jtag_tms ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = jtag_tms ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = jtag_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_d = jtag_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = jtag_tms ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = jtag_tms ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = jtag_tms ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = jtag_tms ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = jtag_tms ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = jtag_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            state_q <= TEST_LOGIC_RESET;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // capture and update act on the edge that leaves the select / exit state
    assign ctrl.capture_dr  = (state_q == SELECT_DR_SCAN) && !jtag_tms;
    assign ctrl.capture_ir  = (state_q == SELECT_IR_SCAN) && !jtag_tms;
    // the edge out of SHIFT still shifts
    assign ctrl.shift_dr    = (state_q == SHIFT_DR);
    assign ctrl.shift_ir    = (state_q == SHIFT_IR);
    assign ctrl.update_dr   = ((state_q == EXIT1_DR) || (state_q == EXIT2_DR)) && jtag_tms;
    assign ctrl.update_ir   = ((state_q == EXIT1_IR) || (state_q == EXIT2_IR)) && jtag_tms;
    assign ctrl.logic_reset = (state_q == TEST_LOGIC_RESET);

    // LEDs are active low, so show the inverted state number
    assign led = ~{2'b00, state_q};

    // TDO moves on the falling edge, half a cycle after the save bit is loaded
    always_ff @(negedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            tdo_q <= 1'b0;
        end
        else if (state_q == SHIFT_IR)
        begin
            tdo_q <= ir_serial;
        end
        else if (state_q == SHIFT_DR)
        begin
            tdo_q <= dr_serial;
        end
    end

    assign jtag_tdo = tdo_q;

    // scan operations are mutually exclusive across both register blocks
    a_strobe_exclusive: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        $onehot0({ctrl.capture_ir, ctrl.shift_ir, ctrl.update_ir,
                  ctrl.capture_dr, ctrl.shift_dr, ctrl.update_dr})
    );

    // five tms ones reach TEST_LOGIC_RESET from any state
    a_tms_reset: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        (jtag_tms && $past(jtag_tms) && $past(jtag_tms, 2) && $past(jtag_tms, 3)
         && $past(jtag_tms, 4)) |=> ctrl.logic_reset
    );

endmodule

// File: logic/tap_instr_pkg.sv
package tap_instr_pkg;

    // instruction and data register words
    typedef logic [31:0] instr_t;
    typedef logic [31:0] data_word_t;

    // supported instructions
    localparam instr_t IDCODE_INSTR = 32'h55555555;
    localparam instr_t BYPASS_INSTR = 32'hFFFFFFFF;
    localparam instr_t CUSTOM_INSTR = 32'h0A0B0C0D;

    // data register selection, exactly one bit set
    typedef struct packed {
        logic sel_idcode;
        logic sel_custom;
        logic sel_bypass;
    } dr_select_t;

endpackage

// File: logic/tap_state_pkg.sv
package tap_state_pkg;

    // IEEE 1149.1 TAP states, numbered as on the LED display
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        // data register branch
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        // instruction register branch
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_t;

    // six board LEDs, lit when low
    typedef logic [5:0] led_t;

    // one-cycle strobes from the controller to the register blocks
    typedef struct packed {
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic logic_reset;
    } tap_ctrl_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the JTAG TAP testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module tb_jtag_tap \
    -f sources.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
logic/tap_state_pkg.sv
logic/tap_instr_pkg.sv
logic/tap_controller.sv
logic/scan_register.sv
logic/instruction_register.sv
logic/data_register_bank.sv
logic/jtag_tap_top.sv
dv/tb_clock_gen.sv
dv/tb_jtag_tap.sv
